//--- rt_pkg.sv
package rt_pkg;

	// Scene coordinates are plain signed integers
	typedef logic signed [15:0] coord_t;

	// Pixel column and row index
	typedef logic [7:0] idx_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t z;
	} vector_t;

	// Rays all run toward plus z, so only the far z bound is kept
	typedef struct packed {
		coord_t xmin;
		coord_t xmax;
		coord_t ymin;
		coord_t ymax;
		coord_t zmax;
	} aabb_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// One entry of the pixel buffer
	typedef struct packed {
		idx_t col;
		idx_t row;
		rgb_t rgb;
	} pix_t;

	typedef struct packed {
		vector_t cam;
		aabb_t   box;
		rgb_t    hit_rgb;
		rgb_t    bg_rgb;
	} render_cfg_t;

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// Register byte offsets
	localparam logic [7:0] reg_ctrl      = 8'h00;
	localparam logic [7:0] reg_status    = 8'h04;
	localparam logic [7:0] reg_cam_x     = 8'h08;
	localparam logic [7:0] reg_cam_y     = 8'h0C;
	localparam logic [7:0] reg_cam_z     = 8'h10;
	localparam logic [7:0] reg_xmin      = 8'h14;
	localparam logic [7:0] reg_xmax      = 8'h18;
	localparam logic [7:0] reg_ymin      = 8'h1C;
	localparam logic [7:0] reg_ymax      = 8'h20;
	localparam logic [7:0] reg_zmax      = 8'h24;
	localparam logic [7:0] reg_hit_rgb   = 8'h28;
	localparam logic [7:0] reg_bg_rgb    = 8'h2C;
	localparam logic [7:0] reg_frame_cnt = 8'h30;

endpackage : rt_pkg

//--- render_ifs.sv
`timescale 1ns/1ns

// Ray stream from the generator to the intersection stage
interface ray_if import rt_pkg::*; ();
	logic    valid;
	logic    ready;
	idx_t    col;
	idx_t    row;
	vector_t org;

	modport src (output valid, col, row, org, input ready);
	modport dst (input valid, col, row, org, output ready);
endinterface : ray_if

// Shaded pixel stream
interface pix_if import rt_pkg::*; ();
	logic valid;
	logic ready;
	idx_t col;
	idx_t row;
	rgb_t rgb;

	modport src (output valid, col, row, rgb, input ready);
	modport dst (input valid, col, row, rgb, output ready);
endinterface : pix_if

//--- ctrl_regs.sv
`timescale 1ns/1ns

module ctrl_regs import rt_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        awvalid,
	output logic        awready,
	input  logic [7:0]  awaddr,
	input  logic        wvalid,
	output logic        wready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	output logic        bvalid,
	input  logic        bready,
	output logic [1:0]  bresp,
	input  logic        arvalid,
	output logic        arready,
	input  logic [7:0]  araddr,
	output logic        rvalid,
	input  logic        rready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	input  logic        frame_done,
	output render_cfg_t cfg,
	output logic        start
);

	localparam int num_cfg = 10;

	// Camera, box and colour words from reg_cam_x up to reg_bg_rgb
	logic [31:0] cfg_r [num_cfg];
	logic [31:0] frame_cnt;
	logic        busy;
	logic        done;
	logic        wr_en;
	logic        rd_en;
	logic [3:0]  wr_idx;
	logic [3:0]  rd_idx;
	logic [31:0] rd_word;
	logic [1:0]  rd_resp;

	function automatic logic is_cfg(input logic [7:0] addr);
		return (addr >= reg_cam_x) && (addr <= reg_bg_rgb) && (addr[1:0] == 2'b00);
	endfunction

	function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
			input logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int i = 0; i < 4; i++) begin
			if (strb[i])
				res[i*8 +: 8] = data[i*8 +: 8];
		end
		return res;
	endfunction

	// Address and data are taken together, one write in flight
	assign wr_en   = awvalid && wvalid && !bvalid;
	assign awready = wr_en;
	assign wready  = wr_en;
	assign arready = !rvalid;
	assign rd_en   = arvalid && arready;
	assign wr_idx  = 4'((awaddr - reg_cam_x) >> 2);
	assign rd_idx  = 4'((araddr - reg_cam_x) >> 2);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bvalid    <= 1'b0;
			bresp     <= resp_okay;
			start     <= 1'b0;
			busy      <= 1'b0;
			done      <= 1'b0;
			frame_cnt <= '0;
			for (int i = 0; i < num_cfg; i++)
				cfg_r[i] <= '0;
		end else begin
			start <= 1'b0;
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (frame_done) begin
				busy      <= 1'b0;
				done      <= 1'b1;
				frame_cnt <= frame_cnt + 32'd1;
			end
			if (wr_en) begin
				bvalid <= 1'b1;
				bresp  <= resp_okay;
				if (is_cfg(awaddr)) begin
					cfg_r[wr_idx] <= merge(cfg_r[wr_idx], wdata, wstrb);
				end else if (awaddr == reg_ctrl) begin
					// Start only from idle
					if (wstrb[0] && wdata[0] && !busy) begin
						start <= 1'b1;
						busy  <= 1'b1;
						done  <= 1'b0;
					end
				end else if (awaddr != reg_status && awaddr != reg_frame_cnt) begin
					bresp <= resp_slverr;
				end
			end
		end
	end

	always_comb begin
		rd_word = '0;
		rd_resp = resp_okay;
		if (is_cfg(araddr)) begin
			rd_word = cfg_r[rd_idx];
		end else begin
			case (araddr)
				reg_ctrl:      rd_word = '0;
				reg_status:    rd_word = {30'b0, done, busy};
				reg_frame_cnt: rd_word = frame_cnt;
				default:       rd_resp = resp_slverr;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rvalid <= 1'b0;
			rdata  <= '0;
			rresp  <= resp_okay;
		end else if (rd_en) begin
			rvalid <= 1'b1;
			rdata  <= rd_word;
			rresp  <= rd_resp;
		end else if (rvalid && rready) begin
			rvalid <= 1'b0;
		end
	end

	// Coordinates sit in the low half of each word
	assign cfg.cam.x    = cfg_r[0][15:0];
	assign cfg.cam.y    = cfg_r[1][15:0];
	assign cfg.cam.z    = cfg_r[2][15:0];
	assign cfg.box.xmin = cfg_r[3][15:0];
	assign cfg.box.xmax = cfg_r[4][15:0];
	assign cfg.box.ymin = cfg_r[5][15:0];
	assign cfg.box.ymax = cfg_r[6][15:0];
	assign cfg.box.zmax = cfg_r[7][15:0];
	assign cfg.hit_rgb  = cfg_r[8][23:0];
	assign cfg.bg_rgb   = cfg_r[9][23:0];

endmodule : ctrl_regs

//--- ray_gen.sv
`timescale 1ns/1ns

module ray_gen import rt_pkg::*; #(
	parameter int img_w = 8,
	parameter int img_h = 4
) (
	input  logic        clk,
	input  logic        arst_n,
	input  render_cfg_t cfg,
	input  logic        start,
	ray_if.src          ray
);

	localparam idx_t last_col = idx_t'(img_w - 1);
	localparam idx_t last_row = idx_t'(img_h - 1);

	logic fire;

	assign fire = ray.valid && ray.ready;

	// Raster scan, column fastest
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ray.valid <= 1'b0;
			ray.col   <= '0;
			ray.row   <= '0;
		end else if (start) begin
			ray.valid <= 1'b1;
			ray.col   <= '0;
			ray.row   <= '0;
		end else if (fire) begin
			if (ray.col == last_col) begin
				ray.col <= '0;
				if (ray.row == last_row)
					ray.valid <= 1'b0;
				else
					ray.row <= ray.row + idx_t'(1);
			end else begin
				ray.col <= ray.col + idx_t'(1);
			end
		end
	end

	// Orthographic camera with unit basis, origin offset by pixel index
	assign ray.org = '{
		x: cfg.cam.x + coord_t'(ray.col),
		y: cfg.cam.y + coord_t'(ray.row),
		z: cfg.cam.z
	};

endmodule : ray_gen

//--- aabb_test.sv
`timescale 1ns/1ns

module aabb_test import rt_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  render_cfg_t cfg,
	ray_if.dst          ray,
	pix_if.src          pix
);

	logic en;
	logic hit_x;
	logic hit_y;
	logic hit_z;
	logic v1;
	logic hit1;
	idx_t col1;
	idx_t row1;

	// Whole pipe stalls while the output word is waiting
	assign en        = !pix.valid || pix.ready;
	assign ray.ready = en;

	// Slab tests, all signed
	assign hit_x = (ray.org.x >= cfg.box.xmin) && (ray.org.x <= cfg.box.xmax);
	assign hit_y = (ray.org.y >= cfg.box.ymin) && (ray.org.y <= cfg.box.ymax);
	assign hit_z = ray.org.z <= cfg.box.zmax;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			v1        <= 1'b0;
			pix.valid <= 1'b0;
		end else if (en) begin
			v1        <= ray.valid;
			pix.valid <= v1;
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			// Stage one keeps the hit flag
			col1    <= ray.col;
			row1    <= ray.row;
			hit1    <= hit_x && hit_y && hit_z;
			// Stage two shades
			pix.col <= col1;
			pix.row <= row1;
			pix.rgb <= hit1 ? cfg.hit_rgb : cfg.bg_rgb;
		end
	end

endmodule : aabb_test

//--- pixel_fifo.sv
`timescale 1ns/1ns

module pixel_fifo import rt_pkg::*; #(
	parameter int fifo_depth = 16
) (
	input  logic clk,
	input  logic arst_n,
	pix_if.dst   wr,
	pix_if.src   rd
);

	localparam int data_w = $bits(pix_t);
	localparam int ptr_w  = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int cnt_w  = $clog2(fifo_depth + 1);

	logic [data_w-1:0] mem [fifo_depth];
	logic [ptr_w-1:0]  wr_ptr;
	logic [ptr_w-1:0]  rd_ptr;
	logic [cnt_w-1:0]  count;
	logic              push;
	logic              pop;
	pix_t              wr_entry;
	pix_t              head;

	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
		return (ptr == ptr_w'(fifo_depth - 1)) ? '0 : ptr + ptr_w'(1);
	endfunction

	assign wr.ready = count != cnt_w'(fifo_depth);
	assign rd.valid = count != '0;
	assign push     = wr.valid && wr.ready;
	assign pop      = rd.valid && rd.ready;

	assign wr_entry = '{col: wr.col, row: wr.row, rgb: wr.rgb};
	assign head     = pix_t'(mem[rd_ptr]);
	assign rd.col   = head.col;
	assign rd.row   = head.row;
	assign rd.rgb   = head.rgb;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= wr_entry;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			// Simultaneous push and pop leaves the count alone
			if (push && !pop)
				count <= count + cnt_w'(1);
			else if (pop && !push)
				count <= count - cnt_w'(1);
		end
	end

endmodule : pixel_fifo

//--- frame_out.sv
`timescale 1ns/1ns

module frame_out import rt_pkg::*; #(
	parameter int img_w = 8,
	parameter int img_h = 4
) (
	input  logic clk,
	input  logic arst_n,
	pix_if.dst   pix,
	output logic pix_valid,
	input  logic pix_ready,
	output idx_t pix_col,
	output idx_t pix_row,
	output rgb_t pix_rgb,
	output logic frame_done
);

	localparam idx_t last_col = idx_t'(img_w - 1);
	localparam idx_t last_row = idx_t'(img_h - 1);

	logic last_xfer;

	assign pix_valid = pix.valid;
	assign pix.ready = pix_ready;
	assign pix_col   = pix.col;
	assign pix_row   = pix.row;
	assign pix_rgb   = pix.rgb;

	// Bottom right pixel leaving marks the end of the frame
	assign last_xfer = pix.valid && pix_ready && (pix.col == last_col) && (pix.row == last_row);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			frame_done <= 1'b0;
		else
			frame_done <= last_xfer;
	end

endmodule : frame_out

//--- render_top.sv
`timescale 1ns/1ns

module render_top import rt_pkg::*; #(
	parameter int img_w      = 8,
	parameter int img_h      = 4,
	parameter int fifo_depth = 16
) (
	input  logic        clk,
	input  logic        arst_n,

	// AXI4-Lite register port
	input  logic        awvalid,
	output logic        awready,
	input  logic [7:0]  awaddr,
	input  logic        wvalid,
	output logic        wready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	output logic        bvalid,
	input  logic        bready,
	output logic [1:0]  bresp,
	input  logic        arvalid,
	output logic        arready,
	input  logic [7:0]  araddr,
	output logic        rvalid,
	input  logic        rready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,

	// Pixel stream
	output logic        pix_valid,
	input  logic        pix_ready,
	output idx_t        pix_col,
	output idx_t        pix_row,
	output rgb_t        pix_rgb
);

	render_cfg_t cfg;
	logic        start;
	logic        frame_done;

	ray_if ray_s ();
	pix_if pix_pipe ();
	pix_if pix_buf ();

	ctrl_regs cr (
		.clk, .arst_n,
		.awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
		.bvalid, .bready, .bresp,
		.arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
		.frame_done, .cfg, .start
	);

	ray_gen #(.img_w(img_w), .img_h(img_h)) rg (
		.clk, .arst_n, .cfg, .start, .ray(ray_s)
	);

	aabb_test at (.clk, .arst_n, .cfg, .ray(ray_s), .pix(pix_pipe));

	pixel_fifo #(.fifo_depth(fifo_depth)) pb (
		.clk, .arst_n, .wr(pix_pipe), .rd(pix_buf)
	);

	frame_out #(.img_w(img_w), .img_h(img_h)) fo (
		.clk, .arst_n, .pix(pix_buf),
		.pix_valid, .pix_ready, .pix_col, .pix_row, .pix_rgb, .frame_done
	);

endmodule : render_top

//--- tb_render_top.sv
`timescale 1ns/1ns

module tb_render_top import rt_pkg::*; ();

	localparam int img_w       = 8;
	localparam int img_h       = 4;
	localparam int npix        = img_w * img_h;
	localparam int hs_limit    = 64;
	localparam int first_limit = 20;
	localparam int poll_limit  = 20;
	localparam int frame_limit = 20000;

	// One table row per frame
	typedef struct {
		coord_t      cam_x;
		coord_t      cam_y;
		coord_t      cam_z;
		coord_t      xmin;
		coord_t      xmax;
		coord_t      ymin;
		coord_t      ymax;
		coord_t      zmax;
		logic [23:0] hit_rgb;
		logic [23:0] bg_rgb;
		int          bp_pct;
		int          stall_len;
	} frame_t;

	logic        clk;
	logic        arst_n;
	logic        awvalid;
	logic        awready;
	logic [7:0]  awaddr;
	logic        wvalid;
	logic        wready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        bvalid;
	logic        bready;
	logic [1:0]  bresp;
	logic        arvalid;
	logic        arready;
	logic [7:0]  araddr;
	logic        rvalid;
	logic        rready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        pix_valid;
	logic        pix_ready;
	idx_t        pix_col;
	idx_t        pix_row;
	rgb_t        pix_rgb;

	frame_t frames[$];
	int     cur = 0;
	bit     armed = 1'b0;
	int     bp_pct = 0;
	int     stall_len = 0;
	int     rx_count = 0;
	int     pix_pos;
	int     err_value = 0;
	int     err_pix = 0;
	int     err_other = 0;

	render_top #(.img_w(img_w), .img_h(img_h), .fifo_depth(16)) dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Back-pressure on the pixel port as random drops or long low stretches
	initial begin
		int stall_cnt;
		stall_cnt = 0;
		pix_ready = 1'b1;
		void'($urandom(32'h7dafaeec));
		forever begin
			@(negedge clk);
			if (stall_len > 0) begin
				pix_ready = (stall_cnt % (stall_len + 4)) >= stall_len;
				stall_cnt++;
			end else begin
				pix_ready = ($urandom % 100) >= 32'(bp_pct);
			end
		end
	end

	function automatic bit mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		bit bad;
		bad = 1'b0;
		assert (got == exp) else begin
			$display("Error: %s = %h, expected %h", name, got, exp);
			bad = 1'b1;
		end
		return bad;
	endfunction

	// Hit rule of the orthographic camera against the box
	function automatic logic [23:0] expect_rgb(input frame_t f, input int col, input int row);
		int x;
		int y;
		int z;
		x = int'(f.cam_x) + col;
		y = int'(f.cam_y) + row;
		z = int'(f.cam_z);
		if (x >= int'(f.xmin) && x <= int'(f.xmax) && y >= int'(f.ymin) &&
				y <= int'(f.ymax) && z <= int'(f.zmax))
			return f.hit_rgb;
		return f.bg_rgb;
	endfunction

	function automatic void add_frame(input int cx, input int cy, input int cz, input int x0,
			input int x1, input int y0, input int y1, input int zm, input logic [23:0] hit,
			input logic [23:0] bg, input int pct, input int stall);
		frame_t f;
		f.cam_x     = coord_t'(cx);
		f.cam_y     = coord_t'(cy);
		f.cam_z     = coord_t'(cz);
		f.xmin      = coord_t'(x0);
		f.xmax      = coord_t'(x1);
		f.ymin      = coord_t'(y0);
		f.ymax      = coord_t'(y1);
		f.zmax      = coord_t'(zm);
		f.hit_rgb   = hit;
		f.bg_rgb    = bg;
		f.bp_pct    = pct;
		f.stall_len = stall;
		frames.push_back(f);
	endfunction

	// Pixel checker takes the position in the frame from the running count
	always @(posedge clk) begin
		if (arst_n && !armed) begin
			assert (!pix_valid) else begin
				err_pix++;
				$display("Pixel stream is active with no frame started (col %0d, row %0d)",
					pix_col, pix_row);
			end
		end else if (arst_n && pix_valid && pix_ready) begin
			pix_pos = rx_count % npix;
			if (mismatch("pix_col", 32'(pix_col), 32'(pix_pos % img_w)))
				err_pix++;
			if (mismatch("pix_row", 32'(pix_row), 32'(pix_pos / img_w)))
				err_pix++;
			if (mismatch("pix_rgb", 32'(pix_rgb),
					32'(expect_rgb(frames[cur], pix_pos % img_w, pix_pos / img_w))))
				err_pix++;
			rx_count++;
		end
	end

	task automatic report_and_finish();
		$display("Errors: value %0d, pixel %0d, other %0d; pixels received %0d",
			err_value, err_pix, err_other, rx_count);
		if (err_value == 0 && err_pix == 0 && err_other == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timeout: %s", what);
		err_other++;
		report_and_finish();
	endtask

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		int n;
		@(negedge clk);
		awvalid = 1'b1;
		wvalid  = 1'b1;
		awaddr  = addr;
		wdata   = data;
		wstrb   = strb;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!(awready && wready) && n < hs_limit);
		if (!(awready && wready))
			abort_on_timeout("write address and data were never accepted");
		@(negedge clk);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!bvalid && n < hs_limit);
		if (!bvalid)
			abort_on_timeout("no write response arrived");
		// Response has to wait one cycle for bready
		@(negedge clk);
		bready = 1'b1;
		@(posedge clk);
		assert (bvalid) else begin
			$display("Write response was withdrawn before bready");
			err_other++;
		end
		resp = bresp;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int n;
		@(negedge clk);
		arvalid = 1'b1;
		araddr  = addr;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!arready && n < hs_limit);
		if (!arready)
			abort_on_timeout("read address was never accepted");
		@(negedge clk);
		arvalid = 1'b0;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!rvalid && n < hs_limit);
		if (!rvalid)
			abort_on_timeout("no read data arrived");
		// Read data has to wait one cycle for rready
		@(negedge clk);
		rready = 1'b1;
		@(posedge clk);
		assert (rvalid) else begin
			$display("Read data was withdrawn before rready");
			err_other++;
		end
		data = rdata;
		resp = rresp;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic write_check(input logic [7:0] addr, input logic [31:0] data,
			input logic [3:0] strb, input logic [1:0] exp_resp);
		logic [1:0] resp;
		axi_write(addr, data, strb, resp);
		if (mismatch($sformatf("bresp @%h", addr), 32'(resp), 32'(exp_resp)))
			err_value++;
	endtask

	task automatic read_check(input logic [7:0] addr, input logic [31:0] exp_data,
			input logic [1:0] exp_resp);
		logic [31:0] data;
		logic [1:0]  resp;
		axi_read(addr, data, resp);
		if (mismatch($sformatf("rresp @%h", addr), 32'(resp), 32'(exp_resp)))
			err_value++;
		if (mismatch($sformatf("rdata @%h", addr), data, exp_data))
			err_value++;
	endtask

	task automatic check_regs();
		logic [31:0] val;
		for (int k = 0; k < 10; k++) begin
			val = 32'h1357_0000 + 32'(k) * 32'h0001_0203;
			write_check(reg_cam_x + 8'(4 * k), val, 4'hF, resp_okay);
		end
		for (int k = 0; k < 10; k++) begin
			val = 32'h1357_0000 + 32'(k) * 32'h0001_0203;
			read_check(reg_cam_x + 8'(4 * k), val, resp_okay);
		end
		// Second write enables bytes 0 and 2 only
		write_check(reg_hit_rgb, 32'h00AABBCC, 4'hF, resp_okay);
		write_check(reg_hit_rgb, 32'h11223344, 4'b0101, resp_okay);
		read_check(reg_hit_rgb, 32'h0022BB44, resp_okay);
	endtask

	task automatic check_access();
		read_check(8'h40, 32'h0, resp_slverr);
		write_check(8'h44, 32'hDEADBEEF, 4'hF, resp_slverr);
		write_check(reg_frame_cnt, 32'h55, 4'hF, resp_okay);
		read_check(reg_frame_cnt, 32'h0, resp_okay);
		read_check(reg_status, 32'h0, resp_okay);
	endtask

	task automatic run_frame(input int idx);
		frame_t      f;
		logic [31:0] vals [10];
		logic [31:0] rd;
		logic [1:0]  resp;
		int          base;
		int          n;
		f = frames[idx];
		vals = '{32'(f.cam_x), 32'(f.cam_y), 32'(f.cam_z), 32'(f.xmin), 32'(f.xmax),
			32'(f.ymin), 32'(f.ymax), 32'(f.zmax), 32'(f.hit_rgb), 32'(f.bg_rgb)};
		for (int k = 0; k < 10; k++)
			write_check(reg_cam_x + 8'(4 * k), vals[k], 4'hF, resp_okay);
		cur       = idx;
		bp_pct    = f.bp_pct;
		stall_len = f.stall_len;
		base      = rx_count;
		armed     = 1'b1;
		write_check(reg_ctrl, 32'h1, 4'h1, resp_okay);
		// With the port always ready the first pixel must come quickly
		if (f.bp_pct == 0 && f.stall_len == 0) begin
			n = 0;
			while (rx_count == base && n < first_limit) begin
				@(negedge clk);
				n++;
			end
			if (rx_count == base)
				abort_on_timeout("first pixel of the frame did not appear");
		end
		read_check(reg_status, 32'h1, resp_okay);
		// Must not restart the running frame
		write_check(reg_ctrl, 32'h1, 4'h1, resp_okay);
		n = 0;
		while (rx_count < base + npix && n < frame_limit) begin
			@(negedge clk);
			n++;
		end
		if (rx_count < base + npix)
			abort_on_timeout("frame did not deliver all its pixels");
		n = 0;
		do begin
			axi_read(reg_status, rd, resp);
			n++;
		end while (rd[0] && n < poll_limit);
		if (rd[0])
			abort_on_timeout("busy did not clear after the last pixel");
		read_check(reg_status, 32'h2, resp_okay);
		read_check(reg_frame_cnt, 32'(idx + 1), resp_okay);
		// Stray pixels would show up in this quiet stretch
		repeat (40) @(negedge clk);
		if (mismatch("pixels in frame", 32'(rx_count - base), 32'(npix)))
			err_value++;
		armed = 1'b0;
	endtask

	initial begin
		awvalid = 1'b0;
		awaddr  = '0;
		wvalid  = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		bready  = 1'b0;
		arvalid = 1'b0;
		araddr  = '0;
		rready  = 1'b0;
		arst_n  = 1'b0;

		// cam x y z, box xmin xmax ymin ymax zmax, hit, background, ready low %, stall
		add_frame(0, 0, 0, -5, 20, -5, 20, 10, 24'hFF2010, 24'h000040, 0, 0);
		add_frame(100, 100, 0, 0, 7, 0, 3, 10, 24'h00FF00, 24'h101010, 30, 0);
		add_frame(-4, -2, -3, -2, 1, -1, 0, 0, 24'h123456, 24'hABCDEF, 0, 0);
		add_frame(0, 0, 50, -100, 100, -100, 100, 49, 24'hFFFFFF, 24'h0000AA, 30, 0);
		add_frame(2, 1, 0, 3, 6, 1, 2, 5, 24'h808000, 24'h000080, 0, 30);

		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		if (mismatch("awready", 32'(awready), 32'h0))
			err_value++;
		if (mismatch("wready", 32'(wready), 32'h0))
			err_value++;
		if (mismatch("bvalid", 32'(bvalid), 32'h0))
			err_value++;
		if (mismatch("rvalid", 32'(rvalid), 32'h0))
			err_value++;
		if (mismatch("arready", 32'(arready), 32'h1))
			err_value++;
		if (mismatch("pix_valid", 32'(pix_valid), 32'h0))
			err_value++;
		// Idle time with no start
		repeat (20) @(negedge clk);
		check_regs();
		check_access();
		foreach (frames[i])
			run_frame(i);
		report_and_finish();
	end

endmodule : tb_render_top

//--- flist.f
rt_pkg.sv
render_ifs.sv
ctrl_regs.sv
ray_gen.sv
aabb_test.sv
pixel_fifo.sv
frame_out.sv
render_top.sv
tb_render_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_render_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)
